/* sim.f */
+incdir+.
sram_pkg.sv
sram_bank.sv
sram_bank_group.sv
sram_write_router.sv
sram_read_select.sv
sram_system.sv
tb_sram_system.sv

/* sram_bank.sv */
`timescale 1ns/10ps
`include "sram_config.svh"

// single-port memory that keeps a real and an imaginary word at each address
// a write takes the port for the cycle, otherwise the read address is sampled
module sram_bank import sram_pkg::*; #(
    parameter int DEPTH_WIDTH = `ADDR_L_WIDTH
) (
    input  logic                   clk_i,
    input  logic                   wen_i,
    input  logic [DEPTH_WIDTH-1:0] addr_wr_i,
    input  logic [DEPTH_WIDTH-1:0] addr_rd_i,
    input  sfp_t                   wdata_r_i,
    input  sfp_t                   wdata_i_i,
    output sfp_t                   rdata_r_o,
    output sfp_t                   rdata_i_o
);

    // element 0 is the real word and element 1 the imaginary word
    sfp_t [1:0] mem [0:(2**DEPTH_WIDTH)-1];

    // read register for the pair, same packing as the array
    sfp_t [1:0] rdata_q;

    // one port only, so a write cycle leaves the read register untouched
    // and the caller sees the previous read data once more
    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            mem[addr_wr_i] <= {wdata_i_i, wdata_r_i};
        end else begin
            rdata_q <= mem[addr_rd_i];
        end
    end

    // split the stored pair back into its two halves
    assign rdata_r_o = rdata_q[0];
    assign rdata_i_o = rdata_q[1];

endmodule

/* sram_bank_group.sv */
`timescale 1ns/10ps
`include "sram_config.svh"

// one group of four banks sharing a write and a read address
// bank 0 is always a long bank, banks 1 to 3 take SHORT_WIDTH bits
module sram_bank_group import sram_pkg::*; #(
    parameter int SHORT_WIDTH = `ADDR_S_WIDTH
) (
    input  logic                        clk_i,
    input  logic    [`NUM_LANES-1:0]    wen_i,
    input  addr_l_t                     addr_wr_i,
    input  addr_l_t                     addr_rd_i,
    input  sfp_t    [`NUM_LANES-1:0]    wdata_r_i,
    input  sfp_t    [`NUM_LANES-1:0]    wdata_i_i,
    output sfp_t    [`NUM_LANES-1:0]    rdata_r_o,
    output sfp_t    [`NUM_LANES-1:0]    rdata_i_o
);

    // bank 0 is the one column writes land in, so it keeps the full depth
    sram_bank #(
        .DEPTH_WIDTH (`ADDR_L_WIDTH)
    ) u_bank_long (
        .clk_i     (clk_i),
        .wen_i     (wen_i[0]),
        .addr_wr_i (addr_wr_i),
        .addr_rd_i (addr_rd_i),
        .wdata_r_i (wdata_r_i[0]),
        .wdata_i_i (wdata_i_i[0]),
        .rdata_r_o (rdata_r_o[0]),
        .rdata_i_o (rdata_i_o[0])
    );

    // the remaining banks are short except in group 0
    // addresses above the short range alias onto the low bits
    for (genvar b = 1; b < `NUM_LANES; b++) begin : g_bank
        sram_bank #(
            .DEPTH_WIDTH (SHORT_WIDTH)
        ) u_bank (
            .clk_i     (clk_i),
            .wen_i     (wen_i[b]),
            .addr_wr_i (addr_wr_i[SHORT_WIDTH-1:0]),
            .addr_rd_i (addr_rd_i[SHORT_WIDTH-1:0]),
            .wdata_r_i (wdata_r_i[b]),
            .wdata_i_i (wdata_i_i[b]),
            .rdata_r_o (rdata_r_o[b]),
            .rdata_i_o (rdata_i_o[b])
        );
    end

endmodule

/* sram_config.svh */
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// width of one real or imaginary sample word
`define SFP_WIDTH 16

// long banks hold 128 words and need the full address
`define ADDR_L_WIDTH 7

// short banks hold 32 words and only see the low address bits
`define ADDR_S_WIDTH 5

// number of bank groups in the system
`define NUM_GROUPS 4

// number of data lanes, which is also the number of banks per group
`define NUM_LANES 4

// write strobe carries one bit per group plus one column bit,
// the read strobe carries one row bit per group and one column bit per lane

`endif

/* sram_pkg.sv */
`include "sram_config.svh"

package sram_pkg;

    // one real or imaginary sample word
    typedef logic [`SFP_WIDTH-1:0] sfp_t;

    // group addresses always travel at long width
    // short banks just drop the upper bits
    typedef logic [`ADDR_L_WIDTH-1:0] addr_l_t;

    // write operation decoded from the one-hot write strobe
    // anything that is not one-hot falls back to WR_NONE
    typedef enum logic [2:0] {
        WR_NONE = 3'd0,
        WR_ROW0 = 3'd1,
        WR_ROW1 = 3'd2,
        WR_ROW2 = 3'd3,
        WR_ROW3 = 3'd4,
        WR_COL0 = 3'd5
    } wr_mode_e;

    // read operation decoded from the one-hot read strobe
    // column k returns bank k of every group
    typedef enum logic [3:0] {
        RD_NONE = 4'd0,
        RD_ROW0 = 4'd1,
        RD_ROW1 = 4'd2,
        RD_ROW2 = 4'd3,
        RD_ROW3 = 4'd4,
        RD_COL0 = 4'd5,
        RD_COL1 = 4'd6,
        RD_COL2 = 4'd7,
        RD_COL3 = 4'd8
    } rd_mode_e;

endpackage

/* sram_read_select.sv */
`timescale 1ns/10ps
`include "sram_config.svh"

// picks the output lanes out of the sixteen bank read words
// the mode is registered so it lines up with the registered bank data
module sram_read_select import sram_pkg::*; (
    input  logic                                     clk_i,
    input  logic                                     arst_n_i,
    input  logic [2*`NUM_LANES-1:0]                  ren_i,
    input  sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0]   bank_rdata_r_i,
    input  sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0]   bank_rdata_i_i,
    output sfp_t [`NUM_LANES-1:0]                    dr_sram_o,
    output sfp_t [`NUM_LANES-1:0]                    di_sram_o
);

    localparam int SEL_W = $clog2(`NUM_GROUPS);

    rd_mode_e         rd_mode_d;
    rd_mode_e         rd_mode_q;
    logic             row_hit;
    logic             col_hit;
    logic [SEL_W-1:0] sel_idx;

    // low nibble selects a row, high nibble a column in reversed bit order
    // a strobe that is not one-hot reads as no operation
    always_comb begin
        case (ren_i)
            8'h01:   rd_mode_d = RD_ROW0;
            8'h02:   rd_mode_d = RD_ROW1;
            8'h04:   rd_mode_d = RD_ROW2;
            8'h08:   rd_mode_d = RD_ROW3;
            8'h80:   rd_mode_d = RD_COL0;
            8'h40:   rd_mode_d = RD_COL1;
            8'h20:   rd_mode_d = RD_COL2;
            8'h10:   rd_mode_d = RD_COL3;
            default: rd_mode_d = RD_NONE;
        endcase
    end

    // banks answer one edge after the address, so the mode follows suit
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_mode_q <= RD_NONE;
        end else begin
            rd_mode_q <= rd_mode_d;
        end
    end

    // sel_idx is the group for a row read and the bank for a column read
    always_comb begin
        row_hit = 1'b0;
        col_hit = 1'b0;
        case (rd_mode_q)
            RD_ROW0, RD_ROW1, RD_ROW2, RD_ROW3: row_hit = 1'b1;
            RD_COL0, RD_COL1, RD_COL2, RD_COL3: col_hit = 1'b1;
            default: ;
        endcase
        case (rd_mode_q)
            RD_ROW0, RD_COL0: sel_idx = 2'd0;
            RD_ROW1, RD_COL1: sel_idx = 2'd1;
            RD_ROW2, RD_COL2: sel_idx = 2'd2;
            RD_ROW3, RD_COL3: sel_idx = 2'd3;
            default:          sel_idx = '0;
        endcase
    end

    // with no valid mode the lanes stay at zero
    always_comb begin
        dr_sram_o = '0;
        di_sram_o = '0;
        if (row_hit) begin
            dr_sram_o = bank_rdata_r_i[sel_idx];
            di_sram_o = bank_rdata_i_i[sel_idx];
        end else if (col_hit) begin
            // group 0 ends up on the top lane, group 3 on lane 0
            for (int l = 0; l < `NUM_LANES; l++) begin
                dr_sram_o[l] = bank_rdata_r_i[`NUM_GROUPS-1-l][sel_idx];
                di_sram_o[l] = bank_rdata_i_i[`NUM_GROUPS-1-l][sel_idx];
            end
        end
    end

endmodule

/* sram_system.sv */
`timescale 1ns/10ps
`include "sram_config.svh"

// complex-sample memory for the FFT datapath
// one router, four bank groups and the read lane selector
module sram_system import sram_pkg::*; (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic    [`NUM_GROUPS:0]         wen_i,
    input  addr_l_t [`NUM_GROUPS-1:0]       addr_wr_i,
    input  sfp_t    [`NUM_LANES-1:0]        dr_sram_i,
    input  sfp_t    [`NUM_LANES-1:0]        di_sram_i,
    input  logic    [2*`NUM_LANES-1:0]      ren_i,
    input  addr_l_t [`NUM_GROUPS-1:0]       addr_rd_i,
    output sfp_t    [`NUM_LANES-1:0]        dr_sram_o,
    output sfp_t    [`NUM_LANES-1:0]        di_sram_o
);

    // per-bank write side, indexed by group then bank
    logic [`NUM_GROUPS-1:0][`NUM_LANES-1:0] bank_wen;
    sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0] bank_wdata_r;
    sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0] bank_wdata_i;

    // per-bank read data, same indexing
    sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0] bank_rdata_r;
    sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0] bank_rdata_i;

    sram_write_router u_write_router (
        .wen_i          (wen_i),
        .dr_sram_i      (dr_sram_i),
        .di_sram_i      (di_sram_i),
        .bank_wen_o     (bank_wen),
        .bank_wdata_r_o (bank_wdata_r),
        .bank_wdata_i_o (bank_wdata_i)
    );

    // group 0 is built from long banks only, the others mostly short ones
    for (genvar g = 0; g < `NUM_GROUPS; g++) begin : g_group
        sram_bank_group #(
            .SHORT_WIDTH ((g == 0) ? `ADDR_L_WIDTH : `ADDR_S_WIDTH)
        ) u_group (
            .clk_i     (clk_i),
            .wen_i     (bank_wen[g]),
            .addr_wr_i (addr_wr_i[g]),
            .addr_rd_i (addr_rd_i[g]),
            .wdata_r_i (bank_wdata_r[g]),
            .wdata_i_i (bank_wdata_i[g]),
            .rdata_r_o (bank_rdata_r[g]),
            .rdata_i_o (bank_rdata_i[g])
        );
    end

    sram_read_select u_read_select (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .ren_i          (ren_i),
        .bank_rdata_r_i (bank_rdata_r),
        .bank_rdata_i_i (bank_rdata_i),
        .dr_sram_o      (dr_sram_o),
        .di_sram_o      (di_sram_o)
    );

endmodule

/* sram_tests.txt */
# name op en a0 a1 a2 a3 dr0 dr1 dr2 dr3 di0 di1 di2 di3 (all fields after op in hex)
# W: en is wen, a0-a3 are write addresses per group; R: en is ren, lanes are expected values
# nothing has been read yet
reset_idle     R 00 00 00 00 00 0000 0000 0000 0000 0000 0000 0000 0000
# row writes to each group at address 05
wr_row0        W 01 05 05 05 05 1000 1001 1002 1003 9000 9001 9002 9003
wr_row1        W 02 05 05 05 05 1110 1111 1112 1113 9110 9111 9112 9113
wr_row2        W 04 05 05 05 05 1220 1221 1222 1223 9220 9221 9222 9223
wr_row3        W 08 05 05 05 05 1330 1331 1332 1333 9330 9331 9332 9333
# row reads back, issued back to back
rd_row0        R 01 05 05 05 05 1000 1001 1002 1003 9000 9001 9002 9003
rd_row1        R 02 05 05 05 05 1110 1111 1112 1113 9110 9111 9112 9113
rd_row2        R 04 05 05 05 05 1220 1221 1222 1223 9220 9221 9222 9223
rd_row3        R 08 05 05 05 05 1330 1331 1332 1333 9330 9331 9332 9333
# column k puts group 0 on lane 3 down to group 3 on lane 0
rd_col0        R 80 05 05 05 05 1330 1220 1110 1000 9330 9220 9110 9000
rd_col1        R 40 05 05 05 05 1331 1221 1111 1001 9331 9221 9111 9001
rd_col2        R 20 05 05 05 05 1332 1222 1112 1002 9332 9222 9112 9002
rd_col3        R 10 05 05 05 05 1333 1223 1113 1003 9333 9223 9113 9003
# column write lands lane 3 in group 0 bank 0 through lane 0 in group 3 bank 0
wr_col0        W 10 05 05 05 05 a000 a001 a002 a003 b000 b001 b002 b003
rd_cw_row0     R 01 05 05 05 05 a003 1001 1002 1003 b003 9001 9002 9003
rd_cw_row1     R 02 05 05 05 05 a002 1111 1112 1113 b002 9111 9112 9113
rd_cw_row2     R 04 05 05 05 05 a001 1221 1222 1223 b001 9221 9222 9223
rd_cw_row3     R 08 05 05 05 05 a000 1331 1332 1333 b000 9331 9332 9333
rd_cw_col0     R 80 05 05 05 05 a000 a001 a002 a003 b000 b001 b002 b003
# two write strobes at once must write nothing
wr_two_hot     W 03 05 05 05 05 ffff ffff ffff ffff ffff ffff ffff ffff
rd_keep_row0   R 01 05 05 05 05 a003 1001 1002 1003 b003 9001 9002 9003
rd_keep_row1   R 02 05 05 05 05 a002 1111 1112 1113 b002 9111 9112 9113
# address 2a aliases onto 0a in short banks only
wr_g1_lo       W 02 0a 0a 0a 0a 2000 2001 2002 2003 3000 3001 3002 3003
wr_g1_hi       W 02 2a 2a 2a 2a 4000 4001 4002 4003 5000 5001 5002 5003
wr_g0_lo       W 01 0a 0a 0a 0a 6000 6001 6002 6003 e000 e001 e002 e003
wr_g0_hi       W 01 2a 2a 2a 2a 7000 7001 7002 7003 f000 f001 f002 f003
rd_g1_lo       R 02 0a 0a 0a 0a 2000 4001 4002 4003 3000 5001 5002 5003
rd_g1_hi       R 02 2a 2a 2a 2a 4000 4001 4002 4003 5000 5001 5002 5003
rd_g0_lo       R 01 0a 0a 0a 0a 6000 6001 6002 6003 e000 e001 e002 e003
rd_g0_hi       R 01 2a 2a 2a 2a 7000 7001 7002 7003 f000 f001 f002 f003
# each group takes its own read address
rd_mixed_col0  R 80 0a 0a 05 05 a000 a001 2000 6000 b000 b001 3000 e000
# empty and malformed reads give zero lanes
rd_none        R 00 05 05 05 05 0000 0000 0000 0000 0000 0000 0000 0000
rd_two_row     R 03 05 05 05 05 0000 0000 0000 0000 0000 0000 0000 0000
rd_row_col     R 81 05 05 05 05 0000 0000 0000 0000 0000 0000 0000 0000
# back-to-back reads, then data lasts one cycle only
rd_b2b_row2    R 04 05 05 05 05 a001 1221 1222 1223 b001 9221 9222 9223
rd_b2b_col3    R 10 05 05 05 05 1333 1223 1113 1003 9333 9223 9113 9003
rd_after       R 00 05 05 05 05 0000 0000 0000 0000 0000 0000 0000 0000

/* sram_write_router.sv */
`timescale 1ns/10ps
`include "sram_config.svh"

// turns the one-hot write strobe into per-bank enables and write data
// purely combinational, so a write lands on the edge the strobe is sampled
module sram_write_router import sram_pkg::*; (
    input  logic [`NUM_GROUPS:0]                     wen_i,
    input  sfp_t [`NUM_LANES-1:0]                    dr_sram_i,
    input  sfp_t [`NUM_LANES-1:0]                    di_sram_i,
    output logic [`NUM_GROUPS-1:0][`NUM_LANES-1:0]   bank_wen_o,
    output sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0]   bank_wdata_r_o,
    output sfp_t [`NUM_GROUPS-1:0][`NUM_LANES-1:0]   bank_wdata_i_o
);

    localparam int GRP_W = $clog2(`NUM_GROUPS);

    wr_mode_e         wr_mode;
    logic [GRP_W-1:0] row_grp;

    // anything other than exactly one strobe bit is treated as no write
    always_comb begin
        wr_mode = WR_NONE;
        row_grp = '0;
        case (wen_i)
            5'b00001: begin
                wr_mode = WR_ROW0;
                row_grp = 2'd0;
            end
            5'b00010: begin
                wr_mode = WR_ROW1;
                row_grp = 2'd1;
            end
            5'b00100: begin
                wr_mode = WR_ROW2;
                row_grp = 2'd2;
            end
            5'b01000: begin
                wr_mode = WR_ROW3;
                row_grp = 2'd3;
            end
            5'b10000: begin
                wr_mode = WR_COL0;
            end
            default: begin
                wr_mode = WR_NONE;
            end
        endcase
    end

    // banks that are not written see zero data and a low enable
    always_comb begin
        bank_wen_o     = '0;
        bank_wdata_r_o = '0;
        bank_wdata_i_o = '0;
        case (wr_mode)
            WR_ROW0, WR_ROW1, WR_ROW2, WR_ROW3: begin
                // a row write puts lane b straight into bank b of one group
                bank_wen_o[row_grp]     = '1;
                bank_wdata_r_o[row_grp] = dr_sram_i;
                bank_wdata_i_o[row_grp] = di_sram_i;
            end
            WR_COL0: begin
                // column 0 spreads the lanes over bank 0 of each group,
                // highest lane into group 0
                for (int g = 0; g < `NUM_GROUPS; g++) begin
                    bank_wen_o[g][0]     = 1'b1;
                    bank_wdata_r_o[g][0] = dr_sram_i[`NUM_LANES-1-g];
                    bank_wdata_i_o[g][0] = di_sram_i[`NUM_LANES-1-g];
                end
            end
            default: begin
                bank_wen_o = '0;
            end
        endcase
    end

endmodule

/* tb_sram_system.sv */
`timescale 1ns/10ps
`include "sram_config.svh"

// testbench for the complex-sample memory
// commands come from sram_tests.txt and are applied one per clock
module tb_sram_system import sram_pkg::*; ();

    localparam int MAX_CMDS = 64;
    localparam int NAME_W   = 8 * 32;

    logic                          clk;
    logic                          arst_n;
    logic    [`NUM_GROUPS:0]       wen;
    addr_l_t [`NUM_GROUPS-1:0]     addr_wr;
    sfp_t    [`NUM_LANES-1:0]      dr_in;
    sfp_t    [`NUM_LANES-1:0]      di_in;
    logic    [2*`NUM_LANES-1:0]    ren;
    addr_l_t [`NUM_GROUPS-1:0]     addr_rd;
    sfp_t    [`NUM_LANES-1:0]      dr_out;
    sfp_t    [`NUM_LANES-1:0]      di_out;

    // command table, one entry per data line
    // for a read the lane values are what the DUT must return
    logic    [NAME_W-1:0]          cmd_name [MAX_CMDS];
    logic                          cmd_wr   [MAX_CMDS];
    logic    [7:0]                 cmd_en   [MAX_CMDS];
    addr_l_t [`NUM_GROUPS-1:0]     cmd_addr [MAX_CMDS];
    sfp_t    [`NUM_LANES-1:0]      cmd_dr   [MAX_CMDS];
    sfp_t    [`NUM_LANES-1:0]      cmd_di   [MAX_CMDS];
    int                            n_cmds;

    int   errors;
    int   checks;
    int   cycle_limit;
    logic limit_set;
    logic pend;
    int   pend_idx;

    sram_system uut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .wen_i     (wen),
        .addr_wr_i (addr_wr),
        .dr_sram_i (dr_in),
        .di_sram_i (di_in),
        .ren_i     (ren),
        .addr_rd_i (addr_rd),
        .dr_sram_o (dr_out),
        .di_sram_o (di_out)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // lines whose first token is # are comments
    // every other non-blank line must carry all fifteen fields
    task automatic load_tests();
        int                fd;
        int                cnt;
        logic [8*256-1:0]  line;
        logic [NAME_W-1:0] name;
        logic [31:0]       op;
        int                en;
        int                a0, a1, a2, a3;
        int                r0, r1, r2, r3;
        int                i0, i1, i2, i3;
        n_cmds = 0;
        fd = $fopen("sram_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open sram_tests.txt for reading");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                cnt = $fgets(line, fd);
                if (cnt > 0) begin
                    cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  name, op, en, a0, a1, a2, a3,
                                  r0, r1, r2, r3, i0, i1, i2, i3);
                    if (cnt == 15 && n_cmds < MAX_CMDS && (op == "W" || op == "R")) begin
                        cmd_name[n_cmds] = name;
                        cmd_wr[n_cmds]   = (op == "W");
                        cmd_en[n_cmds]   = en[7:0];
                        cmd_addr[n_cmds] = {a3[`ADDR_L_WIDTH-1:0], a2[`ADDR_L_WIDTH-1:0],
                                            a1[`ADDR_L_WIDTH-1:0], a0[`ADDR_L_WIDTH-1:0]};
                        cmd_dr[n_cmds]   = {r3[`SFP_WIDTH-1:0], r2[`SFP_WIDTH-1:0],
                                            r1[`SFP_WIDTH-1:0], r0[`SFP_WIDTH-1:0]};
                        cmd_di[n_cmds]   = {i3[`SFP_WIDTH-1:0], i2[`SFP_WIDTH-1:0],
                                            i1[`SFP_WIDTH-1:0], i0[`SFP_WIDTH-1:0]};
                        n_cmds++;
                    end else if (cnt > 0 && name != "#") begin
                        $display("ERROR: test line %0s could not be used", name);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_cmds == 0) begin
            $display("ERROR: no test commands were found in sram_tests.txt");
            errors++;
        end
    endtask

    // a write drives the write side only, a read the read side only
    task automatic apply_cmd(input int n);
        if (cmd_wr[n]) begin
            wen     = cmd_en[n][`NUM_GROUPS:0];
            addr_wr = cmd_addr[n];
            dr_in   = cmd_dr[n];
            di_in   = cmd_di[n];
            ren     = '0;
            addr_rd = '0;
        end else begin
            wen     = '0;
            addr_wr = '0;
            dr_in   = '0;
            di_in   = '0;
            ren     = cmd_en[n];
            addr_rd = cmd_addr[n];
        end
    endtask

    task automatic check_lanes(input logic [NAME_W-1:0] name,
                               input sfp_t [`NUM_LANES-1:0] exp_dr,
                               input sfp_t [`NUM_LANES-1:0] exp_di);
        checks++;
        if (dr_out !== exp_dr) begin
            $display("FAIL %0s dr_sram_o expected %h actual %h", name, exp_dr, dr_out);
            errors++;
        end
        if (di_out !== exp_di) begin
            $display("FAIL %0s di_sram_o expected %h actual %h", name, exp_di, di_out);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        limit_set = 1'b0;
        pend      = 1'b0;
        pend_idx  = 0;
        clk       = 1'b0;
        arst_n    = 1'b0;
        wen       = '0;
        addr_wr   = '0;
        dr_in     = '0;
        di_in     = '0;
        // a row read is held through reset so only the reset keeps the mode empty
        ren       = 8'h01;
        addr_rd   = '0;
        load_tests();
        // the limit covers reset, one cycle per command and the last check with room to spare
        cycle_limit = 3 * n_cmds + 20;
        limit_set   = 1'b1;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;
        ren = '0;
        // the registered read mode starts at no operation, so the lanes are zero
        check_lanes("reset", '0, '0);
        // a read sampled at one edge is visible just after the next edge
        for (int n = 0; n < n_cmds; n++) begin
            @(posedge clk);
            #2;
            if (pend) begin
                check_lanes(cmd_name[pend_idx], cmd_dr[pend_idx], cmd_di[pend_idx]);
            end
            apply_cmd(n);
            pend     = !cmd_wr[n];
            pend_idx = n;
        end
        @(posedge clk);
        #2;
        if (pend) begin
            check_lanes(cmd_name[pend_idx], cmd_dr[pend_idx], cmd_di[pend_idx]);
        end
        wen = '0;
        ren = '0;
        finish_run();
    end

    // watchdog counts clocks once the command count is known
    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (limit_set === 1'b1);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout, the commands did not finish within %0d cycles", cycle_limit);
        errors++;
        finish_run();
    end

endmodule
